//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
TOP       := lsu_tb
FILELIST  := tb.f
BUILD_DIR := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- source/lsu_l1d.sv
`timescale 1ns/1ps

module lsu_l1d import lsu_pkg::*; #(
  parameter int unsigned L1D_LINES = 4
) (
  input  logic     clk,
  input  logic     rst_i,
  input  lsu_req_t req_i,
  input  data_t    bus_rdata_i,
  input  logic     bus_rvalid_i,
  input  logic     bus_wready_i,
  input  logic     cacheable_i,
  input  logic     flush_i,
  output logic     hit_o,
  output data_t    hit_data_o
);

  localparam int unsigned IDX_W = $clog2(L1D_LINES);
  // two low bits are the byte offset inside the word
  localparam int unsigned TAG_W = ADDR_W - IDX_W - 2;

  typedef logic [IDX_W-1:0] idx_t;
  typedef logic [TAG_W-1:0] tag_t;

  data_t                data_q  [L1D_LINES];
  tag_t                 tag_q   [L1D_LINES];
  logic [L1D_LINES-1:0] valid_q;

  idx_t idx;
  tag_t tag;
  logic line_match;
  logic load_req;
  logic store_req;
  logic refill;
  logic store_hit;

  assign idx = req_i.addr[IDX_W+1:2];
  assign tag = req_i.addr[ADDR_W-1:IDX_W+2];

  assign load_req  = req_i.avalid & req_i.ren;
  assign store_req = req_i.avalid & req_i.wen;

  // valid line holding this address
  assign line_match = valid_q[idx] & (tag_q[idx] == tag);

  assign hit_o      = load_req & line_match;
  assign hit_data_o = data_q[idx];

  // bus answer to a load inside an enabled window
  assign refill = load_req & bus_rvalid_i & cacheable_i;

  // write-through, no allocate; drop the stale copy once the bus takes it
  assign store_hit = store_req & bus_wready_i & line_match;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      if (refill) begin
        valid_q[idx] <= 1'b1;
      end
      if (store_hit) begin
        valid_q[idx] <= 1'b0;
      end
      // flush wins over anything in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill) begin
      data_q[idx] <= bus_rdata_i;
      tag_q[idx]  <= tag;
    end
  end

  // execute never asks for a load and a store at once
  a_no_hit_on_store: assert property (
    @(posedge clk) disable iff (rst_i)
    !(hit_o && req_i.wen)
  ) else $error("lsu_l1d: hit while store enable is set");

  // a hit never turns up in the cycle the bus is answering
  a_no_hit_with_rvalid: assert property (
    @(posedge clk) disable iff (rst_i)
    !($rose(hit_o) && bus_rvalid_i)
  ) else $error("lsu_l1d: hit rose together with bus rvalid");

endmodule

//--- source/lsu_mem_op.sv
`timescale 1ns/1ps

module lsu_mem_op import lsu_pkg::*; (
  input  mem_op_e    op_i,
  input  logic [1:0] addr_lo_i,
  input  data_t      raw_rdata_i,
  output strb_t      wstrb_o,
  output strb_t      rstrb_o,
  output data_t      rdata_o
);

  data_t shifted;

  // store strobe lanes count up from bit 0
  always_comb begin
    case (op_i)
      OP_SB:   wstrb_o = 8'h01;
      OP_SH:   wstrb_o = 8'h03;
      OP_SW:   wstrb_o = 8'h0f;
      default: wstrb_o = 8'h00;
    endcase
  end

  // signed and unsigned loads read the same lanes
  always_comb begin
    case (op_i)
      OP_LB,
      OP_LBU:  rstrb_o = 8'h01;
      OP_LH,
      OP_LHU:  rstrb_o = 8'h03;
      OP_LW:   rstrb_o = 8'h0f;
      default: rstrb_o = 8'h00;
    endcase
  end

  // bring the addressed byte down to lane 0
  assign shifted = raw_rdata_i >> {addr_lo_i, 3'b000};

  always_comb begin
    case (op_i)
      OP_LB: begin
        rdata_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      OP_LBU: begin
        rdata_o = {24'h0, shifted[7:0]};
      end
      OP_LH: begin
        rdata_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      OP_LHU: begin
        rdata_o = {16'h0, shifted[15:0]};
      end
      OP_LW: begin
        rdata_o = shifted;
      end
      default: begin
        // stores and idle return nothing
        rdata_o = '0;
      end
    endcase
  end

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

  // widths that carry a meaning
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = 8;
  localparam int unsigned CFG_AW = 4;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // only the low 4 bits are used on a 32-bit bus
  typedef logic [STRB_W-1:0] strb_t;

  typedef logic [CFG_AW-1:0] cfg_addr_t;

  // memory operation from execute
  typedef enum logic [3:0] {
    OP_LB   = 4'h0,
    OP_LBU  = 4'h1,
    OP_LH   = 4'h2,
    OP_LHU  = 4'h3,
    OP_LW   = 4'h4,
    OP_SB   = 4'h5,
    OP_SH   = 4'h6,
    OP_SW   = 4'h7,
    OP_NONE = 4'hf
  } mem_op_e;

  // request from execute, held until answered
  typedef struct packed {
    addr_t   addr;
    mem_op_e op;
    data_t   wdata;
    logic    ren;
    logic    wen;
    logic    avalid;
  } lsu_req_t;

  // read channel towards the bus
  typedef struct packed {
    addr_t araddr;
    logic  arvalid;
    strb_t rstrb;
  } bus_rd_req_t;

  // write channel towards the bus
  typedef struct packed {
    addr_t awaddr;
    logic  awvalid;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
  } bus_wr_req_t;

endpackage

//--- source/lsu_region_cfg.sv
`timescale 1ns/1ps

module lsu_region_cfg import lsu_pkg::*; #(
  parameter int unsigned NUM_REGIONS = 3
) (
  input  logic      clk,
  input  logic      rst_i,
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  data_t     cfg_wdata_i,
  output data_t     cfg_rdata_o,
  input  addr_t     addr_i,
  output logic      cacheable_o,
  output logic      flush_o
);

  localparam cfg_addr_t CFG_EN    = 4'd0;
  localparam cfg_addr_t CFG_FLUSH = 4'd1;

  logic [NUM_REGIONS-1:0] en_q;
  addr_t                  base_q  [NUM_REGIONS];
  addr_t                  limit_q [NUM_REGIONS];
  logic                   flush_q;
  logic [NUM_REGIONS-1:0] in_window;
  logic                   flush_wr;

  assign flush_wr = cfg_we_i && (cfg_addr_i == CFG_FLUSH) && cfg_wdata_i[0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      en_q    <= '0;
      flush_q <= 1'b0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == CFG_EN)) begin
        en_q <= cfg_wdata_i[NUM_REGIONS-1:0];
      end
      // single pulse even for back to back writes
      flush_q <= flush_wr & ~flush_q;
    end
  end

  // base at 2+2r and limit at 3+2r
  always_ff @(posedge clk) begin
    for (int r = 0; r < NUM_REGIONS; r++) begin
      if (cfg_we_i && (cfg_addr_i == cfg_addr_t'(2 + 2 * r))) begin
        base_q[r] <= cfg_wdata_i;
      end
      if (cfg_we_i && (cfg_addr_i == cfg_addr_t'(3 + 2 * r))) begin
        limit_q[r] <= cfg_wdata_i;
      end
    end
  end

  // flush reads back as zero like any unmapped index
  always_comb begin
    cfg_rdata_o = '0;
    if (cfg_addr_i == CFG_EN) begin
      cfg_rdata_o = data_t'(en_q);
    end
    for (int r = 0; r < NUM_REGIONS; r++) begin
      if (cfg_addr_i == cfg_addr_t'(2 + 2 * r)) begin
        cfg_rdata_o = base_q[r];
      end
      if (cfg_addr_i == cfg_addr_t'(3 + 2 * r)) begin
        cfg_rdata_o = limit_q[r];
      end
    end
  end

  // limit is exclusive
  always_comb begin
    for (int r = 0; r < NUM_REGIONS; r++) begin
      in_window[r] = en_q[r] && (addr_i >= base_q[r]) && (addr_i < limit_q[r]);
    end
  end

  assign cacheable_o = |in_window;
  assign flush_o     = flush_q;

endmodule

//--- source/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; #(
  parameter int unsigned L1D_LINES   = 4,
  parameter int unsigned NUM_REGIONS = 3
) (
  input  logic        clk,
  input  logic        rst_i,
  // execute side
  input  lsu_req_t    req_i,
  output data_t       rdata_o,
  output logic        rvalid_o,
  output logic        wready_o,
  // bus side
  output bus_rd_req_t rd_req_o,
  input  data_t       bus_rdata_i,
  input  logic        bus_rvalid_i,
  output bus_wr_req_t wr_req_o,
  input  logic        bus_wready_i,
  // config registers
  input  logic        cfg_we_i,
  input  cfg_addr_t   cfg_addr_i,
  input  data_t       cfg_wdata_i,
  output data_t       cfg_rdata_o
);

  logic  hit;
  data_t hit_data;
  data_t raw_rdata;
  strb_t wstrb;
  strb_t rstrb;
  logic  cacheable;
  logic  flush;

  // bus word when the bus answers, cached word on a hit
  assign raw_rdata = bus_rvalid_i ? bus_rdata_i : hit_data;

  lsu_mem_op u_mem_op (
    .op_i        (req_i.op),
    .addr_lo_i   (req_i.addr[1:0]),
    .raw_rdata_i (raw_rdata),
    .wstrb_o     (wstrb),
    .rstrb_o     (rstrb),
    .rdata_o     (rdata_o)
  );

  lsu_l1d #(
    .L1D_LINES (L1D_LINES)
  ) u_l1d (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wready_i (bus_wready_i),
    .cacheable_i  (cacheable),
    .flush_i      (flush),
    .hit_o        (hit),
    .hit_data_o   (hit_data)
  );

  lsu_region_cfg #(
    .NUM_REGIONS (NUM_REGIONS)
  ) u_region_cfg (
    .clk         (clk),
    .rst_i       (rst_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .addr_i      (req_i.addr),
    .cacheable_o (cacheable),
    .flush_o     (flush)
  );

  // a hit answers in the request cycle, otherwise wait for the bus
  assign rvalid_o = bus_rvalid_i | hit;
  assign wready_o = bus_wready_i;

  // load goes out only when the cache cannot answer it
  assign rd_req_o.araddr  = req_i.addr;
  assign rd_req_o.arvalid = req_i.avalid & req_i.ren & ~hit;
  assign rd_req_o.rstrb   = rstrb;

  // stores always reach the bus
  assign wr_req_o.awaddr  = req_i.addr;
  assign wr_req_o.awvalid = req_i.avalid & req_i.wen;
  assign wr_req_o.wdata   = req_i.wdata;
  assign wr_req_o.wstrb   = wstrb;
  assign wr_req_o.wvalid  = req_i.avalid & req_i.wen;

endmodule

//--- tb.f
source/lsu_pkg.sv
source/lsu_mem_op.sv
source/lsu_l1d.sv
source/lsu_region_cfg.sv
source/lsu_top.sv
verification/lsu_tb.sv

//--- verification/lsu_cases.txt
# M word_index data | W name cfg_index wdata | R name cfg_index expected
# A name op addr wdata exp_rdata exp_strb exp_hit (1 = answered by the cache)
M 00 80f17f01
M 01 12345678
M 02 c3a5968f
M 40 fedcba98
M 80 11223344
A lb_off0 LB 00000000 00000000 00000001 01 0
A lb_off1 LB 00000001 00000000 0000007f 01 0
A lb_off2 LB 00000002 00000000 fffffff1 01 0
A lb_off3 LB 00000003 00000000 ffffff80 01 0
A lbu_off0 LBU 00000000 00000000 00000001 01 0
A lbu_off1 LBU 00000001 00000000 0000007f 01 0
A lbu_off2 LBU 00000002 00000000 000000f1 01 0
A lbu_off3 LBU 00000003 00000000 00000080 01 0
A lh_off0 LH 00000000 00000000 00007f01 03 0
A lh_off1 LH 00000001 00000000 fffff17f 03 0
A lh_off2 LH 00000002 00000000 ffff80f1 03 0
A lh_off3 LH 00000003 00000000 00000080 03 0
A lhu_off0 LHU 00000000 00000000 00007f01 03 0
A lhu_off1 LHU 00000001 00000000 0000f17f 03 0
A lhu_off2 LHU 00000002 00000000 000080f1 03 0
A lhu_off3 LHU 00000003 00000000 00000080 03 0
A lw_off0 LW 00000000 00000000 80f17f01 0f 0
A lw_off1 LW 00000001 00000000 0080f17f 0f 0
A lw_off2 LW 00000002 00000000 000080f1 0f 0
A lw_off3 LW 00000003 00000000 00000080 0f 0
W win0_base 2 00000000
W win0_limit 3 00000100
W win1_base 4 00000200
W win1_limit 5 00000280
W win_enable 0 00000003
R win1_base_rd 4 00000200
R win_enable_rd 0 00000003
A lw_004_fill LW 00000004 00000000 12345678 0f 0
A lw_004_cached LW 00000004 00000000 12345678 0f 1
A lhu_006_cached LHU 00000006 00000000 00001234 03 1
A lw_100_uncached_a LW 00000100 00000000 fedcba98 0f 0
A lw_100_uncached_b LW 00000100 00000000 fedcba98 0f 0
A sb_005 SB 00000005 000000aa 00000000 01 0
A lw_004_after_sb LW 00000004 00000000 1234aa78 0f 0
A sh_006 SH 00000006 0000cafe 00000000 03 0
A lw_004_after_sh LW 00000004 00000000 cafeaa78 0f 0
A sw_008 SW 00000008 deadbeef 00000000 0f 0
A lw_008_fill LW 00000008 00000000 deadbeef 0f 0
A lw_008_cached LW 00000008 00000000 deadbeef 0f 1
W flush 1 00000001
R flush_rd 1 00000000
A lw_008_flushed LW 00000008 00000000 deadbeef 0f 0
W win0_disable 0 00000002
A lw_000_off_a LW 00000000 00000000 80f17f01 0f 0
A lw_000_off_b LW 00000000 00000000 80f17f01 0f 0
A lw_200_fill LW 00000200 00000000 11223344 0f 0
A lw_200_cached LW 00000200 00000000 11223344 0f 1

//--- verification/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

  localparam int    CLK_PERIOD  = 40;
  localparam int    L1D_LINES   = 4;
  localparam int    NUM_REGIONS = 3;
  localparam string CASES_FILE  = "verification/lsu_cases.txt";

  // one replayed line of the cases file
  typedef struct packed {
    logic [7:0] kind;
    mem_op_e    op;
    addr_t      addr;
    data_t      wdata;
    data_t      exp_data;
    strb_t      exp_strb;
    logic       exp_hit;
  } case_t;

  logic        clk = 1'b0;
  logic        rst;
  lsu_req_t    req;
  data_t       rdata;
  logic        rvalid;
  logic        wready;
  bus_rd_req_t rd_req;
  data_t       bus_rdata = '0;
  logic        bus_rvalid = 1'b0;
  bus_wr_req_t wr_req;
  logic        bus_wready = 1'b0;
  logic        cfg_we;
  cfg_addr_t   cfg_addr;
  data_t       cfg_wdata;
  data_t       cfg_rdata;

  data_t       mem [256];
  bus_rd_req_t rd_seen;
  bus_wr_req_t wr_seen;
  int          rd_wait = -1;
  int          wr_wait = -1;
  logic        rd_done = 1'b0;
  logic        wr_done = 1'b0;

  case_t       cases [$];
  string       names [$];
  int          line_count  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          error_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  lsu_top #(
    .L1D_LINES   (L1D_LINES),
    .NUM_REGIONS (NUM_REGIONS)
  ) i_dut (
    .clk          (clk),
    .rst_i        (rst),
    .req_i        (req),
    .rdata_o      (rdata),
    .rvalid_o     (rvalid),
    .wready_o     (wready),
    .rd_req_o     (rd_req),
    .bus_rdata_i  (bus_rdata),
    .bus_rvalid_i (bus_rvalid),
    .wr_req_o     (wr_req),
    .bus_wready_i (bus_wready),
    .cfg_we_i     (cfg_we),
    .cfg_addr_i   (cfg_addr),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_rdata_o  (cfg_rdata)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout: %0d cycles passed and the cases were not finished", cycle_count);
      $display("Done: errors found");
      $fatal(1, "timeout expired");
    end
  end

  // bus model looks at the requests as they stood at the clock edge
  always @(posedge clk) begin
    rd_seen <= rd_req;
    wr_seen <= wr_req;
  end

  task automatic write_word(input bus_wr_req_t w);
    int    idx;
    int    lane;
    data_t word;
    idx  = int'(w.awaddr[9:2]);
    word = mem[idx];
    // strobes and data come unshifted so lane 0 lands on the addressed byte
    for (int b = 0; b < 4; b++) begin
      lane = b + int'(w.awaddr[1:0]);
      if (w.wstrb[b] && lane < 4) begin
        word[lane*8 +: 8] = w.wdata[b*8 +: 8];
      end
    end
    mem[idx] = word;
  endtask

  // answers once per request after 0 to 3 extra cycles
  always @(negedge clk) begin
    bus_rvalid = 1'b0;
    bus_wready = 1'b0;
    if (!rd_seen.arvalid) begin
      rd_done = 1'b0;
    end else if (!rd_done) begin
      if (rd_wait < 0) begin
        rd_wait = int'($urandom % 4);
      end
      if (rd_wait == 0) begin
        bus_rdata  = mem[rd_seen.araddr[9:2]];
        bus_rvalid = 1'b1;
        rd_done    = 1'b1;
      end
      rd_wait = rd_wait - 1;
    end
    if (!wr_seen.awvalid) begin
      wr_done = 1'b0;
    end else if (!wr_done) begin
      if (wr_wait < 0) begin
        wr_wait = int'($urandom % 4);
      end
      if (wr_wait == 0) begin
        write_word(wr_seen);
        bus_wready = 1'b1;
        wr_done    = 1'b1;
      end
      wr_wait = wr_wait - 1;
    end
  end

  task automatic fail_and_stop(input string why);
    error_count++;
    if (why.len() > 0) begin
      $display("%s", why);
    end
    $display("Done: errors found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
      fail_and_stop("");
    end
  endtask

  task automatic check_flag(input string name, input bit expected, input bit actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
      fail_and_stop("");
    end
  endtask

  task automatic check_rd_req(input string name, input bus_rd_req_t expected,
                              input bus_rd_req_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected araddr %08h arvalid %0b rstrb %02h, actual %08h %0b %02h",
               name, expected.araddr, expected.arvalid, expected.rstrb,
               actual.araddr, actual.arvalid, actual.rstrb);
      fail_and_stop("");
    end
  endtask

  task automatic check_wr_req(input string name, input bus_wr_req_t expected,
                              input bus_wr_req_t actual);
    if (actual !== expected) begin
      $display("FAIL %s: expected write %h, actual %h", name, expected, actual);
      fail_and_stop("");
    end
  endtask

  function automatic mem_op_e op_from_name(input string s);
    case (s)
      "LB":    return OP_LB;
      "LBU":   return OP_LBU;
      "LH":    return OP_LH;
      "LHU":   return OP_LHU;
      "LW":    return OP_LW;
      "SB":    return OP_SB;
      "SH":    return OP_SH;
      "SW":    return OP_SW;
      default: return OP_NONE;
    endcase
  endfunction

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    string       kind;
    string       name;
    string       op_name;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    case_t       c;
    fd = $fopen(CASES_FILE, "r");
    if (fd == 0) begin
      fail_and_stop({"could not open the cases file ", CASES_FILE});
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%s", kind);
      line_count++;
      c = '0;
      c.kind = kind[0];
      if (kind == "M") begin
        n = $sscanf(line, "%s %h %h", kind, v0, v1);
        mem[v0[7:0]] = v1;
        continue;
      end else if (kind == "W" || kind == "R") begin
        n = $sscanf(line, "%s %s %h %h", kind, name, v0, v1);
        c.addr     = v0;
        c.wdata    = v1;
        c.exp_data = v1;
      end else if (kind == "A") begin
        n = $sscanf(line, "%s %s %s %h %h %h %h %h", kind, name, op_name, v0, v1, v2, v3, v4);
        c.op = op_from_name(op_name);
        if (n != 8 || c.op == OP_NONE) begin
          fail_and_stop({"malformed access line in the cases file: ", line});
        end
        c.addr     = v0;
        c.wdata    = v1;
        c.exp_data = v2;
        c.exp_strb = v3[7:0];
        c.exp_hit  = v4[0];
      end else begin
        fail_and_stop({"unknown line kind in the cases file: ", line});
      end
      cases.push_back(c);
      names.push_back(name);
    end
    $fclose(fd);
  endtask

  task automatic write_cfg(input case_t c);
    @(negedge clk);
    cfg_we    = 1'b1;
    cfg_addr  = cfg_addr_t'(c.addr);
    cfg_wdata = c.wdata;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  task automatic read_cfg(input string name, input case_t c);
    @(negedge clk);
    cfg_addr = cfg_addr_t'(c.addr);
    #(CLK_PERIOD / 4);
    check_data(name, c.exp_data, cfg_rdata);
  endtask

  task automatic replay_access(input string name, input case_t c);
    bit          store;
    int          waited;
    bus_rd_req_t exp_rd;
    bus_wr_req_t exp_wr;
    store = c.op inside {OP_SB, OP_SH, OP_SW};
    @(negedge clk);
    req.addr   = c.addr;
    req.op     = c.op;
    req.wdata  = c.wdata;
    req.ren    = !store;
    req.wen    = store;
    req.avalid = 1'b1;
    // outputs settle a quarter period after the drive
    #(CLK_PERIOD / 4);
    if (store) begin
      exp_wr = '{awaddr: c.addr, awvalid: 1'b1, wdata: c.wdata, wstrb: c.exp_strb,
                 wvalid: 1'b1};
      check_wr_req(name, exp_wr, wr_req);
    end else begin
      exp_rd = '{araddr: c.addr, arvalid: !c.exp_hit, rstrb: c.exp_strb};
      check_rd_req(name, exp_rd, rd_req);
    end
    waited = 0;
    while (!(store ? wready : rvalid)) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      waited++;
    end
    check_flag({name, " answered in request cycle"}, c.exp_hit, waited == 0);
    if (!store) begin
      check_data(name, c.exp_data, rdata);
    end
    @(negedge clk);
    req.avalid = 1'b0;
    req.ren    = 1'b0;
    req.wen    = 1'b0;
    req.op     = OP_NONE;
  endtask

  initial begin
    void'($urandom(53));
    rst       = 1'b1;
    req       = '0;
    req.op    = OP_NONE;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = '0;
    end
    load_cases();
    cycle_limit = line_count * 8;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    foreach (cases[i]) begin
      case (cases[i].kind)
        "W":     write_cfg(cases[i]);
        "R":     read_cfg(names[i], cases[i]);
        default: replay_access(names[i], cases[i]);
      endcase
    end
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
